// File: aib_adapt_avmm_defines.svh
// Register-map sizes, address fields and reset timing, included by the package and RTL
`ifndef AIB_ADAPT_AVMM_DEFINES_SVH
`define AIB_ADAPT_AVMM_DEFINES_SVH

// --------------------------------------------------
// Configuration bus
// --------------------------------------------------
`define AVMM_ADDR_W 17
`define AVMM_DATA_W 32
`define AVMM_BE_W 4

// Channel address ID sits in addr[16:11]
`define AVMM_ID_W 6
`define AVMM_ID_LSB 11

// 0 selects the local bank, 1 the adapter
`define AVMM_REGION_BIT 10

// --------------------------------------------------
// Local register bank
// --------------------------------------------------
`define CSR_WORDS 16
`define CSR_BYTE_W 8
`define CSR_CTRL_NUM 54
`define DPRIO_CTRL_NUM 5
// Byte 59 is reserved, word 15 is the datapath word
`define DATAPATH_WORD 15

// --------------------------------------------------
// Hard reset and read tracking
// --------------------------------------------------
`define HRDRST_DLY 16
`define RDPEND_W 3

`endif

// File: aib_adapt_avmm_pkg.sv
// Shared types of the channel configuration slave, referenced by scoped name from each module
`default_nettype none

`include "aib_adapt_avmm_defines.svh"

package aib_adapt_avmm_pkg;

  typedef logic [`AVMM_ADDR_W-1:0] avmm_addr_t;
  typedef logic [`AVMM_DATA_W-1:0] avmm_data_t;
  typedef logic [`AVMM_BE_W-1:0]   avmm_be_t;
  typedef logic [`AVMM_ID_W-1:0]   addr_id_t;
  typedef logic [`CSR_BYTE_W-1:0]  csr_byte_t;

  // Host or slave request, 55 bits
  typedef struct packed {
    logic       write;
    logic       read;
    avmm_addr_t addr;
    avmm_data_t wdata;
    avmm_be_t   byte_en;
  } avmm_req_t;

  typedef struct packed {
    avmm_data_t rdata;
    logic       rdatavld;
    logic       waitreq;
  } avmm_rsp_t;

  // Word 15, byte 63 down to byte 60
  typedef struct packed {
    logic [1:0] rsvd;
    logic       tx_rd_adj_en;
    logic       tx_wr_adj_en;
    logic       rx_rd_adj_en;
    logic       rx_wr_adj_en;
    logic [1:0] tx_fifo_rd_clk_sel;
    logic [1:0] tx_adapter_lpbk_mode;
    logic [2:0] txswap_en;
    logic [2:0] rxswap_en;
    logic       rx_aib_lpbk_en;
    logic       tx_wa_en;
    logic       tx_double_read;
    logic [2:0] tx_phcomp_rd_delay;
    logic [1:0] tx_fifo_mode;
    logic       rx_lpbk;
    logic       rx_wm_en;
    logic       rx_double_write;
    logic [2:0] rx_phcomp_rd_delay;
    logic [1:0] rx_fifo_mode;
  } datapath_ctl_t;

  typedef enum logic [1:0] {
    HRDRST_IDLE = 2'd0,
    HRDRST_WAIT = 2'd1,
    HRDRST_DONE = 2'd2
  } hrdrst_state_t;

endpackage

`default_nettype wire

// File: avmm_hrdrst_timer.sv
// Down-counter for the hard-reset release delay, loaded by the sequencer
`default_nettype none

`include "aib_adapt_avmm_defines.svh"

module avmm_hrdrst_timer (
  input  wire  i_cfg_avmm_clk,
  input  wire  i_rst_n,
  input  wire  i_start,
  output logic o_expired
);

  localparam int CNT_W = $clog2(`HRDRST_DLY + 1);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge i_cfg_avmm_clk) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
    end else if (i_start) begin
      cnt_q <= CNT_W'(`HRDRST_DLY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Stale zero must not count while a load is arriving
  assign o_expired = (cnt_q == '0) & ~i_start;

endmodule

`default_nettype wire

// File: avmm_hrdrst_sm.sv
// Hard-reset release sequencer, qualified by user mode and CSR ready and timed by a delay counter
`default_nettype none

`include "aib_adapt_avmm_defines.svh"

module avmm_hrdrst_sm (
  input  wire  i_cfg_avmm_clk,
  input  wire  i_rst_n,
  input  wire  i_usermode,
  input  wire  i_csr_rdy,
  input  wire  i_dly_expired,
  output logic o_dly_start,
  output logic o_hard_rst_n
);

  aib_adapt_avmm_pkg::hrdrst_state_t state_q;
  aib_adapt_avmm_pkg::hrdrst_state_t state_d;
  logic                              qual_ok;

  assign qual_ok = i_usermode & i_csr_rdy;

  // Timer load fires on the edge that leaves IDLE
  assign o_dly_start = (state_q == aib_adapt_avmm_pkg::HRDRST_IDLE) & qual_ok;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      aib_adapt_avmm_pkg::HRDRST_IDLE: begin
        if (qual_ok) begin
          state_d = aib_adapt_avmm_pkg::HRDRST_WAIT;
        end
      end
      aib_adapt_avmm_pkg::HRDRST_WAIT: begin
        if (!qual_ok) begin
          state_d = aib_adapt_avmm_pkg::HRDRST_IDLE;
        end else if (i_dly_expired) begin
          state_d = aib_adapt_avmm_pkg::HRDRST_DONE;
        end
      end
      aib_adapt_avmm_pkg::HRDRST_DONE: begin
        if (!qual_ok) begin
          state_d = aib_adapt_avmm_pkg::HRDRST_IDLE;
        end
      end
      default: begin
        state_d = aib_adapt_avmm_pkg::HRDRST_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_cfg_avmm_clk) begin
    if (!i_rst_n) begin
      state_q      <= aib_adapt_avmm_pkg::HRDRST_IDLE;
      o_hard_rst_n <= 1'b0;
    end else begin
      state_q      <= state_d;
      // Rise one edge after DONE, drop on the first edge a qualifier is lost
      o_hard_rst_n <= (state_q == aib_adapt_avmm_pkg::HRDRST_DONE) & qual_ok;
    end
  end

endmodule

`default_nettype wire

// File: avmm_csr_bank.sv
// Local bank of channel control registers with byte writes and decoded control outputs
`default_nettype none

`include "aib_adapt_avmm_defines.svh"

module avmm_csr_bank (
  input  wire                                 i_cfg_avmm_clk,
  input  wire                                 i_rst_n,
  input  wire                                 i_csr_wr,
  input  wire                                 i_csr_rd,
  input  wire [$clog2(`CSR_WORDS)-1:0]        i_csr_word,
  input  wire aib_adapt_avmm_pkg::avmm_be_t   i_csr_be,
  input  wire aib_adapt_avmm_pkg::avmm_data_t i_csr_wdata,
  output aib_adapt_avmm_pkg::avmm_data_t      o_csr_rdata,
  output logic                                o_csr_rdatavld,
  output aib_adapt_avmm_pkg::csr_byte_t       o_csr_ctrl [`CSR_CTRL_NUM],
  output aib_adapt_avmm_pkg::csr_byte_t       o_dprio_ctrl [`DPRIO_CTRL_NUM],
  output aib_adapt_avmm_pkg::datapath_ctl_t   o_datapath
);

  localparam int BYTES_PER_WORD = `AVMM_DATA_W / `CSR_BYTE_W;

  aib_adapt_avmm_pkg::avmm_data_t csr_q [`CSR_WORDS];

  // --------------------------------------------------
  // Register file
  // --------------------------------------------------
  always_ff @(posedge i_cfg_avmm_clk) begin
    if (!i_rst_n) begin
      for (int w = 0; w < `CSR_WORDS; w++) begin
        csr_q[w] <= '0;
      end
    end else if (i_csr_wr) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (i_csr_be[b]) begin
          csr_q[i_csr_word][b*`CSR_BYTE_W +: `CSR_BYTE_W] <=
            i_csr_wdata[b*`CSR_BYTE_W +: `CSR_BYTE_W];
        end
      end
    end
  end

  // One-cycle read, every bit returns as written
  always_ff @(posedge i_cfg_avmm_clk) begin
    if (!i_rst_n) begin
      o_csr_rdata    <= '0;
      o_csr_rdatavld <= 1'b0;
    end else begin
      o_csr_rdatavld <= i_csr_rd;
      if (i_csr_rd) begin
        o_csr_rdata <= csr_q[i_csr_word];
      end
    end
  end

  // --------------------------------------------------
  // Byte map
  // --------------------------------------------------
  // CSR control in bytes 0 to 53
  for (genvar i = 0; i < `CSR_CTRL_NUM; i++) begin : g_csr_ctrl
    assign o_csr_ctrl[i] =
      csr_q[i / BYTES_PER_WORD][(i % BYTES_PER_WORD)*`CSR_BYTE_W +: `CSR_BYTE_W];
  end

  // DPRIO control follows directly after
  for (genvar i = 0; i < `DPRIO_CTRL_NUM; i++) begin : g_dprio_ctrl
    localparam int IDX = `CSR_CTRL_NUM + i;
    assign o_dprio_ctrl[i] =
      csr_q[IDX / BYTES_PER_WORD][(IDX % BYTES_PER_WORD)*`CSR_BYTE_W +: `CSR_BYTE_W];
  end

  assign o_datapath = aib_adapt_avmm_pkg::datapath_ctl_t'(csr_q[`DATAPATH_WORD]);

endmodule

`default_nettype wire

// File: avmm_cfg_rdmux.sv
// Address decode and response merge between the host, the local CSR bank and the adapter
`default_nettype none

`include "aib_adapt_avmm_defines.svh"

module avmm_cfg_rdmux (
  input  wire                                 i_cfg_avmm_clk,
  input  wire                                 i_rst_n,
  input  wire aib_adapt_avmm_pkg::addr_id_t   i_addr_id,
  input  wire aib_adapt_avmm_pkg::avmm_req_t  i_avmm_req,
  input  wire aib_adapt_avmm_pkg::avmm_rsp_t  i_adpt_rsp,
  input  wire aib_adapt_avmm_pkg::avmm_data_t i_csr_rdata,
  input  wire                                 i_csr_rdatavld,
  output aib_adapt_avmm_pkg::avmm_rsp_t       o_avmm_rsp,
  output logic                                o_adpt_cfg_write,
  output logic                                o_adpt_cfg_read,
  output logic                                o_csr_wr,
  output logic                                o_csr_rd,
  output logic [$clog2(`CSR_WORDS)-1:0]       o_csr_word,
  output aib_adapt_avmm_pkg::avmm_be_t        o_csr_be,
  output aib_adapt_avmm_pkg::avmm_data_t      o_csr_wdata
);

  logic                 id_match;
  logic                 adpt_sel;
  logic                 local_sel;
  logic                 rd_hold;
  logic                 rdpend_full;
  logic                 adpt_rd_acc;
  logic                 miss_rd_acc;
  logic                 miss_rdvld_q;
  logic [`RDPEND_W-1:0] rdpend_q;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  assign id_match  = (i_avmm_req.addr[`AVMM_ID_LSB +: `AVMM_ID_W] == i_addr_id);
  assign adpt_sel  = id_match & i_avmm_req.addr[`AVMM_REGION_BIT];
  assign local_sel = id_match & ~i_avmm_req.addr[`AVMM_REGION_BIT];

  // Anything pending at the adapter must drain before a non-adapter read
  assign rd_hold     = (rdpend_q != '0);
  assign rdpend_full = &rdpend_q;

  assign o_adpt_cfg_write = adpt_sel & i_avmm_req.write;
  assign o_adpt_cfg_read  = adpt_sel & i_avmm_req.read & ~rdpend_full;
  assign adpt_rd_acc      = o_adpt_cfg_read & ~i_adpt_rsp.waitreq;

  assign o_csr_wr    = local_sel & i_avmm_req.write;
  assign o_csr_rd    = local_sel & i_avmm_req.read & ~rd_hold;
  assign o_csr_word  = i_avmm_req.addr[$clog2(`CSR_WORDS)+1:2];
  assign o_csr_be    = i_avmm_req.byte_en;
  assign o_csr_wdata = i_avmm_req.wdata;

  // Foreign ID, reads answer zero and writes drop
  assign miss_rd_acc = ~id_match & i_avmm_req.read & ~rd_hold;

  // --------------------------------------------------
  // Pending adapter reads
  // --------------------------------------------------
  always_ff @(posedge i_cfg_avmm_clk) begin
    if (!i_rst_n) begin
      rdpend_q     <= '0;
      miss_rdvld_q <= 1'b0;
    end else begin
      miss_rdvld_q <= miss_rd_acc;
      if (adpt_rd_acc && !i_adpt_rsp.rdatavld) begin
        rdpend_q <= rdpend_q + 1'b1;
      end else if (!adpt_rd_acc && i_adpt_rsp.rdatavld && rd_hold) begin
        rdpend_q <= rdpend_q - 1'b1;
      end
    end
  end

  // Response merge
  always_comb begin
    o_avmm_rsp.rdatavld = i_adpt_rsp.rdatavld | i_csr_rdatavld | miss_rdvld_q;
    if (i_adpt_rsp.rdatavld) begin
      o_avmm_rsp.rdata = i_adpt_rsp.rdata;
    end else if (i_csr_rdatavld) begin
      o_avmm_rsp.rdata = i_csr_rdata;
    end else begin
      o_avmm_rsp.rdata = '0;
    end
    if (adpt_sel) begin
      o_avmm_rsp.waitreq = i_adpt_rsp.waitreq | (i_avmm_req.read & rdpend_full);
    end else begin
      o_avmm_rsp.waitreq = i_avmm_req.read & rd_hold;
    end
  end

endmodule

`default_nettype wire

// File: aib_adapt_avmm.sv
// Channel configuration slave top, connecting request steering, local CSRs and hard reset
`default_nettype none

`include "aib_adapt_avmm_defines.svh"

module aib_adapt_avmm (
  input  wire                                 i_cfg_avmm_clk,
  input  wire                                 i_rst_n,
  input  wire aib_adapt_avmm_pkg::addr_id_t   i_addr_id,
  input  wire aib_adapt_avmm_pkg::avmm_req_t  i_avmm_req,
  input  wire aib_adapt_avmm_pkg::avmm_rsp_t  i_adpt_rsp,
  input  wire                                 i_usermode,
  input  wire                                 i_csr_rdy,
  output aib_adapt_avmm_pkg::avmm_rsp_t       o_avmm_rsp,
  output logic                                o_adpt_cfg_write,
  output logic                                o_adpt_cfg_read,
  output aib_adapt_avmm_pkg::csr_byte_t       o_csr_ctrl [`CSR_CTRL_NUM],
  output aib_adapt_avmm_pkg::csr_byte_t       o_dprio_ctrl [`DPRIO_CTRL_NUM],
  output aib_adapt_avmm_pkg::datapath_ctl_t   o_datapath,
  output logic                                o_hard_rst_n
);

  logic                               csr_wr;
  logic                               csr_rd;
  logic [$clog2(`CSR_WORDS)-1:0]      csr_word;
  aib_adapt_avmm_pkg::avmm_be_t       csr_be;
  aib_adapt_avmm_pkg::avmm_data_t     csr_wdata;
  aib_adapt_avmm_pkg::avmm_data_t     csr_rdata;
  logic                               csr_rdatavld;
  logic                               dly_start;
  logic                               dly_expired;

  avmm_cfg_rdmux u_cfg_rdmux (
    .i_cfg_avmm_clk   (i_cfg_avmm_clk),
    .i_rst_n          (i_rst_n),
    .i_addr_id        (i_addr_id),
    .i_avmm_req       (i_avmm_req),
    .i_adpt_rsp       (i_adpt_rsp),
    .i_csr_rdata      (csr_rdata),
    .i_csr_rdatavld   (csr_rdatavld),
    .o_avmm_rsp       (o_avmm_rsp),
    .o_adpt_cfg_write (o_adpt_cfg_write),
    .o_adpt_cfg_read  (o_adpt_cfg_read),
    .o_csr_wr         (csr_wr),
    .o_csr_rd         (csr_rd),
    .o_csr_word       (csr_word),
    .o_csr_be         (csr_be),
    .o_csr_wdata      (csr_wdata)
  );

  avmm_csr_bank u_csr_bank (
    .i_cfg_avmm_clk (i_cfg_avmm_clk),
    .i_rst_n        (i_rst_n),
    .i_csr_wr       (csr_wr),
    .i_csr_rd       (csr_rd),
    .i_csr_word     (csr_word),
    .i_csr_be       (csr_be),
    .i_csr_wdata    (csr_wdata),
    .o_csr_rdata    (csr_rdata),
    .o_csr_rdatavld (csr_rdatavld),
    .o_csr_ctrl     (o_csr_ctrl),
    .o_dprio_ctrl   (o_dprio_ctrl),
    .o_datapath     (o_datapath)
  );

  avmm_hrdrst_sm u_hrdrst_sm (
    .i_cfg_avmm_clk (i_cfg_avmm_clk),
    .i_rst_n        (i_rst_n),
    .i_usermode     (i_usermode),
    .i_csr_rdy      (i_csr_rdy),
    .i_dly_expired  (dly_expired),
    .o_dly_start    (dly_start),
    .o_hard_rst_n   (o_hard_rst_n)
  );

  avmm_hrdrst_timer u_hrdrst_timer (
    .i_cfg_avmm_clk (i_cfg_avmm_clk),
    .i_rst_n        (i_rst_n),
    .i_start        (dly_start),
    .o_expired      (dly_expired)
  );

endmodule

`default_nettype wire

// File: tb_aib_adapt_avmm.sv
// Self-checking testbench for the channel configuration slave, run from the file list
`default_nettype none

`include "aib_adapt_avmm_defines.svh"

module tb_aib_adapt_avmm;

  localparam int          HALF_PERIOD = 20;
  localparam int          SAMPLE_DLY  = HALF_PERIOD - 5;
  localparam int          MAX_ROWS    = 64;
  localparam logic [5:0]  CHAN_ID     = 6'h2A;
  localparam logic [5:0]  OTHER_ID    = 6'h15;
  localparam logic [31:0] ADPT_XOR    = 32'hC3A5_0000;

  logic                                clk;
  logic                                rst_n;
  aib_adapt_avmm_pkg::addr_id_t        addr_id;
  aib_adapt_avmm_pkg::avmm_req_t       avmm_req;
  aib_adapt_avmm_pkg::avmm_rsp_t       adpt_rsp;
  logic                                usermode;
  logic                                csr_rdy;
  aib_adapt_avmm_pkg::avmm_rsp_t       avmm_rsp;
  logic                                adpt_cfg_write;
  logic                                adpt_cfg_read;
  aib_adapt_avmm_pkg::csr_byte_t       csr_ctrl [`CSR_CTRL_NUM];
  aib_adapt_avmm_pkg::csr_byte_t       dprio_ctrl [`DPRIO_CTRL_NUM];
  aib_adapt_avmm_pkg::datapath_ctl_t   datapath;
  logic                                hard_rst_n;

  // Stimulus table and reference register image
  bit          tbl_wr   [MAX_ROWS];
  logic [16:0] tbl_addr [MAX_ROWS];
  logic [31:0] tbl_data [MAX_ROWS];
  logic [3:0]  tbl_be   [MAX_ROWS];
  logic [31:0] tbl_exp  [MAX_ROWS];
  string       tbl_name [MAX_ROWS];
  logic [31:0] ref_mem  [`CSR_WORDS];
  int          row_cnt = 0;

  logic [31:0] exp_q [$];
  string       name_q [$];
  logic [31:0] adpt_data_q [$];
  int          adpt_ready_q [$];
  int          cyc = 0;
  int          cycle_limit = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;

  aib_adapt_avmm uut (
    .i_cfg_avmm_clk   (clk),
    .i_rst_n          (rst_n),
    .i_addr_id        (addr_id),
    .i_avmm_req       (avmm_req),
    .i_adpt_rsp       (adpt_rsp),
    .i_usermode       (usermode),
    .i_csr_rdy        (csr_rdy),
    .o_avmm_rsp       (avmm_rsp),
    .o_adpt_cfg_write (adpt_cfg_write),
    .o_adpt_cfg_read  (adpt_cfg_read),
    .o_csr_ctrl       (csr_ctrl),
    .o_dprio_ctrl     (dprio_ctrl),
    .o_datapath       (datapath),
    .o_hard_rst_n     (hard_rst_n)
  );

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("error %s expected %08h actual %08h", name, exp, act);
    end
  endtask

  function automatic logic [16:0] local_addr(input logic [5:0] id, input int w);
    return {id, 1'b0, 4'b0000, w[3:0], 2'b00};
  endfunction

  function automatic logic [16:0] adpt_addr(input logic [5:0] id, input int off);
    return {id, 1'b1, off[9:0]};
  endfunction

  function automatic logic [31:0] adapter_data(input logic [16:0] addr);
    return {15'd0, addr} ^ ADPT_XOR;
  endfunction

  function automatic logic [7:0] byte_pattern(input int i);
    return 8'(i * 37 + 11);
  endfunction

  function automatic logic [31:0] word_pattern(input int w);
    logic [31:0] val;
    for (int b = 0; b < 4; b++) begin
      val[b*8 +: 8] = byte_pattern(4 * w + b);
    end
    return val;
  endfunction

  function automatic logic [7:0] ref_byte(input int i);
    return ref_mem[i / 4][(i % 4) * 8 +: 8];
  endfunction

  // Expected read data follows the decode rules of the register map
  task automatic add_row(input bit is_wr, input logic [16:0] addr, input logic [31:0] data,
                         input logic [3:0] be, input string name);
    logic [31:0] exp;
    exp = '0;
    if (addr[16:11] == CHAN_ID && !addr[10]) begin
      if (is_wr) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) ref_mem[addr[5:2]][b*8 +: 8] = data[b*8 +: 8];
        end
      end else begin
        exp = ref_mem[addr[5:2]];
      end
    end else if (addr[16:11] == CHAN_ID && !is_wr) begin
      exp = adapter_data(addr);
    end
    tbl_wr[row_cnt]   = is_wr;
    tbl_addr[row_cnt] = addr;
    tbl_data[row_cnt] = data;
    tbl_be[row_cnt]   = be;
    tbl_exp[row_cnt]  = exp;
    tbl_name[row_cnt] = name;
    row_cnt++;
  endtask

  task automatic build_table();
    for (int w = 0; w < `CSR_WORDS; w++) ref_mem[w] = '0;
    for (int w = 0; w < `CSR_WORDS; w++) begin
      add_row(1'b1, local_addr(CHAN_ID, w), word_pattern(w), 4'hF, $sformatf("full_wr_%0d", w));
    end
    for (int w = 0; w < `CSR_WORDS; w++) begin
      add_row(1'b0, local_addr(CHAN_ID, w), '0, 4'hF, $sformatf("full_rd_%0d", w));
    end
    add_row(1'b1, local_addr(CHAN_ID, 3), 32'hDEAD_BEEF, 4'b0101, "part_wr_3");
    add_row(1'b1, local_addr(CHAN_ID, 7), 32'h1122_3344, 4'b1000, "part_wr_7");
    add_row(1'b1, local_addr(CHAN_ID, 13), 32'h5555_AAAA, 4'b0110, "part_wr_13");
    add_row(1'b1, local_addr(CHAN_ID, 15), 32'hCAFE_F00D, 4'b0010, "part_wr_15");
    add_row(1'b0, local_addr(CHAN_ID, 3), '0, 4'hF, "part_rd_3");
    add_row(1'b0, local_addr(CHAN_ID, 7), '0, 4'hF, "part_rd_7");
    add_row(1'b0, local_addr(CHAN_ID, 13), '0, 4'hF, "part_rd_13");
    add_row(1'b0, local_addr(CHAN_ID, 15), '0, 4'hF, "part_rd_15");
    // Several adapter reads in flight, local reads in between
    add_row(1'b0, adpt_addr(CHAN_ID, 'h004), '0, 4'hF, "adpt_rd_004");
    add_row(1'b0, adpt_addr(CHAN_ID, 'h0A8), '0, 4'hF, "adpt_rd_0a8");
    add_row(1'b0, adpt_addr(CHAN_ID, 'h1FC), '0, 4'hF, "adpt_rd_1fc");
    add_row(1'b0, local_addr(CHAN_ID, 0), '0, 4'hF, "mix_local_rd_0");
    add_row(1'b0, adpt_addr(CHAN_ID, 'h3F0), '0, 4'hF, "adpt_rd_3f0");
    add_row(1'b0, adpt_addr(CHAN_ID, 'h010), '0, 4'hF, "adpt_rd_010");
    add_row(1'b0, local_addr(CHAN_ID, 7), '0, 4'hF, "mix_local_rd_7");
    add_row(1'b1, adpt_addr(CHAN_ID, 'h020), 32'h0F0F_1234, 4'hF, "adpt_wr_020");
    add_row(1'b0, adpt_addr(CHAN_ID, 'h100), '0, 4'hF, "adpt_rd_100");
    add_row(1'b0, local_addr(CHAN_ID, 15), '0, 4'hF, "mix_local_rd_15");
    // Foreign channel ID
    add_row(1'b1, local_addr(OTHER_ID, 2), 32'h0BAD_0BAD, 4'hF, "miss_wr_2");
    add_row(1'b0, local_addr(OTHER_ID, 2), '0, 4'hF, "miss_rd_2");
    add_row(1'b0, adpt_addr(OTHER_ID, 'h044), '0, 4'hF, "miss_adpt_rd_044");
    add_row(1'b0, local_addr(CHAN_ID, 2), '0, 4'hF, "after_miss_rd_2");
  endtask

  // Holds the request until it is accepted
  task automatic run_access(input int idx);
    bit accepted;
    bit to_adpt;
    accepted = 1'b0;
    // Adapter strobes only for the own ID in the adapter region
    to_adpt  = (tbl_addr[idx][16:11] == CHAN_ID) && tbl_addr[idx][10];
    @(negedge clk);
    avmm_req.write   = tbl_wr[idx];
    avmm_req.read    = ~tbl_wr[idx];
    avmm_req.addr    = tbl_addr[idx];
    avmm_req.wdata   = tbl_data[idx];
    avmm_req.byte_en = tbl_be[idx];
    while (!accepted) begin
      #(SAMPLE_DLY);
      if (!avmm_rsp.waitreq) begin
        accepted = 1'b1;
        check_value($sformatf("%s_adpt_strobes", tbl_name[idx]),
                    32'({to_adpt & tbl_wr[idx], to_adpt & ~tbl_wr[idx]}),
                    32'({adpt_cfg_write, adpt_cfg_read}));
        if (!tbl_wr[idx]) begin
          exp_q.push_back(tbl_exp[idx]);
          name_q.push_back(tbl_name[idx]);
        end
      end
      @(posedge clk);
      if (!accepted) @(negedge clk);
    end
  endtask

  task automatic test_hard_reset();
    usermode = 1'b1;
    csr_rdy  = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_value("hrdrst_one_qual", 32'd0, 32'(hard_rst_n));
    end
    csr_rdy = 1'b1;
    for (int k = 0; k <= `HRDRST_DLY + 2; k++) begin
      @(negedge clk);
      check_value($sformatf("hrdrst_edge_%0d", k), 32'(k == `HRDRST_DLY + 2), 32'(hard_rst_n));
    end
    usermode = 1'b0;
    @(negedge clk);
    check_value("hrdrst_fall", 32'd0, 32'(hard_rst_n));
  endtask

  task automatic check_byte_map();
    int idx;
    for (int i = 0; i < `CSR_CTRL_NUM; i++) begin
      check_value($sformatf("csr_ctrl_%0d", i), 32'(ref_byte(i)), 32'(csr_ctrl[i]));
    end
    for (int j = 0; j < `DPRIO_CTRL_NUM; j++) begin
      idx = `CSR_CTRL_NUM + j;
      check_value($sformatf("dprio_ctrl_%0d", j), 32'(ref_byte(idx)), 32'(dprio_ctrl[j]));
    end
    check_value("datapath_word", ref_mem[`DATAPATH_WORD], datapath);
    check_value("datapath_tx_fifo_rd_clk_sel", 32'(ref_mem[`DATAPATH_WORD][25:24]),
                32'(datapath.tx_fifo_rd_clk_sel));
    check_value("datapath_txswap_en", 32'(ref_mem[`DATAPATH_WORD][21:19]),
                32'(datapath.txswap_en));
    check_value("datapath_tx_phcomp_rd_delay", 32'(ref_mem[`DATAPATH_WORD][12:10]),
                32'(datapath.tx_phcomp_rd_delay));
    check_value("datapath_rx_fifo_mode", 32'(ref_mem[`DATAPATH_WORD][1:0]),
                32'(datapath.rx_fifo_mode));
  endtask

  // --------------------------------------------------
  // Adapter model and read monitor
  // --------------------------------------------------
  initial begin : adapter_model
    adpt_rsp = '0;
    void'($urandom(32'hab1f));
    forever begin
      @(negedge clk);
      if (adpt_ready_q.size() != 0 && adpt_ready_q[0] <= cyc) begin
        adpt_rsp.rdatavld = 1'b1;
        adpt_rsp.rdata    = adpt_data_q.pop_front();
        void'(adpt_ready_q.pop_front());
      end else begin
        adpt_rsp.rdatavld = 1'b0;
        adpt_rsp.rdata    = '0;
      end
      adpt_rsp.waitreq = (($urandom % 4) == 0);
      #(SAMPLE_DLY);
      if (adpt_cfg_read && !adpt_rsp.waitreq) begin
        adpt_data_q.push_back(adapter_data(avmm_req.addr));
        adpt_ready_q.push_back(cyc + 1 + int'($urandom % 5));
      end
    end
  end

  initial begin : read_monitor
    forever begin
      @(negedge clk);
      #(SAMPLE_DLY);
      if (rst_n && avmm_rsp.rdatavld) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("read data %08h returned with no read outstanding", avmm_rsp.rdata);
        end else begin
          check_value(name_q.pop_front(), exp_q.pop_front(), avmm_rsp.rdata);
        end
      end
    end
  end

  initial begin : watchdog
    @(posedge clk);
    while (cyc < cycle_limit) @(posedge clk);
    $display("timeout after %0d cycles, the DUT stopped responding", cyc);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main_seq
    rst_n    = 1'b0;
    addr_id  = CHAN_ID;
    avmm_req = '0;
    usermode = 1'b0;
    csr_rdy  = 1'b0;
    build_table();
    cycle_limit = row_cnt * 40 + 200;
    repeat (8) @(negedge clk);
    check_value("reset_rdatavld", 32'd0, 32'(avmm_rsp.rdatavld));
    check_value("reset_adpt_strobes", 32'd0, 32'({adpt_cfg_write, adpt_cfg_read}));
    check_value("reset_hard_rst_n", 32'd0, 32'(hard_rst_n));
    rst_n = 1'b1;
    test_hard_reset();
    for (int i = 0; i < row_cnt; i++) begin
      run_access(i);
    end
    @(negedge clk);
    avmm_req = '0;
    while (exp_q.size() != 0) @(negedge clk);
    check_byte_map();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: aib_adapt_avmm.f
+incdir+.
aib_adapt_avmm_pkg.sv
avmm_hrdrst_timer.sv
avmm_hrdrst_sm.sv
avmm_csr_bank.sv
avmm_cfg_rdmux.sv
aib_adapt_avmm.sv
tb_aib_adapt_avmm.sv

// File: Makefile
# Verilator build and run of the channel configuration slave testbench

VERILATOR ?= verilator
TOP       ?= tb_aib_adapt_avmm
FILELIST  ?= aib_adapt_avmm.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(wildcard *.sv *.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation reported failures, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
